// ==== pool_geom_pkg.sv ====
package pool_geom_pkg;

	// One DMA word, also one lane of an atom
	localparam int WORD_W = 16;

	typedef logic signed [WORD_W-1:0] word_t;

	// Largest window is 2**3 = 8 atoms
	localparam int MAX_WINDOW_LOG2 = 3;

	// Guard bits so a full window sum never overflows
	localparam int ACC_W = WORD_W + MAX_WINDOW_LOG2;

	typedef logic signed [ACC_W-1:0] acc_t; // Per-lane running max or sum

endpackage

// ==== pool_ctrl_pkg.sv ====
package pool_ctrl_pkg;

	// Opcodes accepted on i_op, the rest are ignored
	typedef enum logic [2:0] {
		OP_MPOOL = 3'd2, // Signed max over the window
		OP_APOOL = 3'd3  // Sum then shift by window_log2
	} op_e;

	// Controller states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0, // Waiting for i_start
		ST_BUSY  = 2'd1, // Reading words, pooling windows
		ST_CLEAR = 2'd2, // Line boundary, one cycle
		ST_DONE  = 2'd3  // Layer end, raises o_ready
	} state_e;

endpackage

// ==== pool_cfg_if.sv ====
`timescale 1ns/1ps

interface pool_cfg_if #(
	parameter int BURST_LEN = 4
);
	import pool_ctrl_pkg::*;

	logic       run;         // High while the controller is in ST_BUSY
	op_e        op;          // Latched opcode
	logic [1:0] window_log2; // Latched window exponent
	logic       window_done; // Pulse when a window result is produced

	// True once a full atom of lanes has been collected
	function automatic logic atom_full(input int lanes);
		return lanes == BURST_LEN;
	endfunction

	// Controller side
	modport ctrl (
		output run, op, window_log2,
		input  window_done
	);

	// Datapath side
	modport unit (
		input  run, op, window_log2,
		output window_done,
		import atom_full
	);

endinterface

// ==== burst_deserializer.sv ====
`timescale 1ns/1ps

module burst_deserializer #(
	parameter int BURST_LEN = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  pool_geom_pkg::word_t i_data,
	input  logic                 i_data_we,
	pool_cfg_if.unit             cfg,
	output pool_geom_pkg::word_t o_atom [BURST_LEN],
	output logic                 o_atom_valid
);
	import pool_geom_pkg::*;

	localparam int CNT_W = $clog2(BURST_LEN + 1); // Counts 0..BURST_LEN

	logic [CNT_W-1:0] lane_cnt; // Words taken into the current atom
	word_t            shift_q [BURST_LEN];
	logic             full;

	assign full = cfg.atom_full(int'(lane_cnt));

	// Newest word enters at the top lane, so lane 0 ends up with the oldest
	always_ff @(posedge clk) begin
		if (i_data_we) begin
			for (int l = 0; l < BURST_LEN - 1; l++)
				shift_q[l] <= shift_q[l + 1];
			shift_q[BURST_LEN-1] <= i_data;
		end
		if (full)
			o_atom <= shift_q; // Snapshot before the next atom overwrites it
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else if (!cfg.run) begin // Restart at every line boundary
			lane_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= full; // One-cycle pulse
			if (full)
				lane_cnt <= i_data_we ? CNT_W'(1) : '0; // Word may arrive in the same cycle
			else if (i_data_we)
				lane_cnt <= lane_cnt + 1'b1;
		end
	end

endmodule

// ==== pool_unit.sv ====
`timescale 1ns/1ps

module pool_unit #(
	parameter int BURST_LEN = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	pool_cfg_if.unit             cfg,
	input  pool_geom_pkg::word_t i_atom [BURST_LEN],
	input  logic                 i_atom_valid,
	output pool_geom_pkg::word_t o_result [BURST_LEN],
	output logic                 o_result_valid
);
	import pool_geom_pkg::*;
	import pool_ctrl_pkg::*;

	logic [MAX_WINDOW_LOG2-1:0] atom_cnt; // Atoms already folded into this window
	logic                       first_atom;
	logic                       last_atom;

	acc_t acc_q [BURST_LEN]; // Running value per lane
	acc_t acc_d [BURST_LEN]; // Value after folding in i_atom
	acc_t avg   [BURST_LEN]; // acc_d divided by window size

	assign first_atom = (atom_cnt == '0);
	// Window of 2**window_log2 atoms
	assign last_atom  = (atom_cnt == MAX_WINDOW_LOG2'((1 << cfg.window_log2) - 1));

	// Per-lane combine
	always_comb begin
		for (int l = 0; l < BURST_LEN; l++) begin
			if (first_atom) begin
				acc_d[l] = acc_t'(i_atom[l]); // Window start loads the lane
			end else if (cfg.op == OP_MPOOL) begin
				// Signed maximum
				acc_d[l] = (acc_t'(i_atom[l]) > acc_q[l]) ? acc_t'(i_atom[l]) : acc_q[l];
			end else begin
				acc_d[l] = acc_q[l] + acc_t'(i_atom[l]); // Sum for average
			end
			// Arithmetic shift rounds toward minus infinity
			avg[l] = acc_d[l] >>> cfg.window_log2;
		end
	end

	// Lane values and result registers
	always_ff @(posedge clk) begin
		if (i_atom_valid)
			acc_q <= acc_d;
		if (i_atom_valid && last_atom) begin
			for (int l = 0; l < BURST_LEN; l++) begin
				if (cfg.op == OP_MPOOL)
					o_result[l] <= acc_d[l][WORD_W-1:0]; // Max always fits a word
				else
					o_result[l] <= avg[l][WORD_W-1:0];   // Mean always fits a word
			end
		end
	end

	// Window position and result strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			atom_cnt       <= '0;
			o_result_valid <= 1'b0;
		end else if (!cfg.run) begin
			atom_cnt       <= '0; // Next line starts a fresh window
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= i_atom_valid && last_atom;
			if (i_atom_valid) begin
				if (last_atom)
					atom_cnt <= '0;
				else
					atom_cnt <= atom_cnt + 1'b1;
			end
		end
	end

	// Controller counts windows off the same strobe
	assign cfg.window_done = o_result_valid;

endmodule

// ==== writeback_serializer.sv ====
`timescale 1ns/1ps

module writeback_serializer #(
	parameter int BURST_LEN = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  pool_geom_pkg::word_t i_result [BURST_LEN],
	input  logic                 i_result_valid,
	output logic                 o_wr_en,
	output pool_geom_pkg::word_t o_wr_data
);
	import pool_geom_pkg::*;

	localparam int LANE_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

	word_t             res_q [BURST_LEN]; // Held result atom
	logic [LANE_W-1:0] lane;              // Lane currently on o_wr_data

	// Result atom capture
	always_ff @(posedge clk) begin
		if (i_result_valid)
			res_q <= i_result;
	end

	// Write-back counter, one lane per cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_wr_en <= 1'b0;
			lane    <= '0;
		end else if (i_result_valid) begin
			o_wr_en <= 1'b1; // Lane 0 goes out first
			lane    <= '0;
		end else if (o_wr_en) begin
			if (lane == LANE_W'(BURST_LEN - 1))
				o_wr_en <= 1'b0; // Burst complete
			else
				lane <= lane + 1'b1;
		end
	end

	assign o_wr_data = res_q[lane];

endmodule

// ==== engine_ctrl.sv ====
`timescale 1ns/1ps

module engine_ctrl (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_start,
	input  logic [2:0] i_op,
	input  logic [1:0] i_window_log2,
	input  logic [7:0] i_o_side,
	input  logic [7:0] i_lines,
	pool_cfg_if.ctrl   cfg,
	output logic       o_rd_en,
	output logic       o_line_finish,
	output logic       o_layer_finish,
	output logic       o_ready
);
	import pool_ctrl_pkg::*;

	state_e     state_q;
	state_e     state_d;
	op_e        op_q;
	logic [1:0] wlog_q;
	logic [7:0] o_side_q;  // Windows per line
	logic [7:0] lines_q;   // Lines per layer
	logic [7:0] win_cnt;   // Windows finished in this line
	logic [7:0] line_cnt;  // Lines finished in this layer
	logic       start_ok;
	logic       last_win;
	logic       last_line;

	assign start_ok  = i_start && (i_op == OP_MPOOL || i_op == OP_APOOL); // Other codes ignored
	assign last_win  = (win_cnt + 8'd1 == o_side_q);
	assign last_line = (line_cnt + 8'd1 == lines_q);

	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:  if (start_ok) state_d = ST_BUSY;
			ST_BUSY:  if (cfg.window_done && last_win) state_d = ST_CLEAR;
			ST_CLEAR: state_d = last_line ? ST_DONE : ST_BUSY; // Layer end or next line
			ST_DONE:  state_d = ST_IDLE;
			default:  state_d = ST_IDLE;
		endcase
	end

	// State, counters, latched config and status pulses
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q        <= ST_IDLE;
			op_q           <= OP_MPOOL;
			wlog_q         <= '0;
			o_side_q       <= '0;
			lines_q        <= '0;
			win_cnt        <= '0;
			line_cnt       <= '0;
			o_line_finish  <= 1'b0;
			o_layer_finish <= 1'b0;
			o_ready        <= 1'b0;
		end else begin
			state_q        <= state_d;
			o_line_finish  <= 1'b0; // Pulses by default
			o_layer_finish <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (start_ok) begin
						op_q     <= op_e'(i_op);
						wlog_q   <= i_window_log2;
						o_side_q <= i_o_side;
						lines_q  <= i_lines;
						win_cnt  <= '0;
						line_cnt <= '0;
						o_ready  <= 1'b0; // Dropped on an accepted start
					end
				end
				ST_BUSY: begin
					if (cfg.window_done) begin
						if (last_win) begin
							win_cnt        <= '0;
							o_line_finish  <= 1'b1;      // Lands in the ST_CLEAR cycle
							o_layer_finish <= last_line; // Same cycle on the final line
						end else begin
							win_cnt <= win_cnt + 8'd1;
						end
					end
				end
				ST_CLEAR: begin
					if (last_line) begin
						line_cnt <= '0;
						o_ready  <= 1'b1; // Rises in ST_DONE
					end else begin
						line_cnt <= line_cnt + 8'd1;
					end
				end
				default: ;
			endcase
		end
	end

	// Read request level doubles as the datapath run level
	assign o_rd_en         = (state_q == ST_BUSY);
	assign cfg.run         = o_rd_en;
	assign cfg.op          = op_q;
	assign cfg.window_log2 = wlog_q;

endmodule

// ==== pool_engine_top.sv ====
`timescale 1ns/1ps

module pool_engine_top #(
	parameter int BURST_LEN = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        i_start,
	input  logic [2:0]  i_op,
	input  logic [1:0]  i_window_log2,
	input  logic [7:0]  i_o_side,
	input  logic [7:0]  i_lines,
	input  logic [15:0] i_data,
	input  logic        i_data_we,
	output logic        o_rd_en,
	output logic        o_wr_en,
	output logic [15:0] o_wr_data,
	output logic        o_line_finish,
	output logic        o_layer_finish,
	output logic        o_ready
);
	import pool_geom_pkg::*;

	word_t atom [BURST_LEN];   // Deserialized atom
	logic  atom_valid;
	word_t result [BURST_LEN]; // Pooled atom
	logic  result_valid;

	// Run control and window status between controller and datapath
	pool_cfg_if #(.BURST_LEN(BURST_LEN)) cfg ();

	engine_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_op           (i_op),
		.i_window_log2  (i_window_log2),
		.i_o_side       (i_o_side),
		.i_lines        (i_lines),
		.cfg            (cfg.ctrl),
		.o_rd_en        (o_rd_en),
		.o_line_finish  (o_line_finish),
		.o_layer_finish (o_layer_finish),
		.o_ready        (o_ready)
	);

	burst_deserializer #(.BURST_LEN(BURST_LEN)) u_deser (
		.clk          (clk),
		.rst          (rst),
		.i_data       (i_data),
		.i_data_we    (i_data_we),
		.cfg          (cfg.unit),
		.o_atom       (atom),
		.o_atom_valid (atom_valid)
	);

	pool_unit #(.BURST_LEN(BURST_LEN)) u_pool (
		.clk            (clk),
		.rst            (rst),
		.cfg            (cfg.unit),
		.i_atom         (atom),
		.i_atom_valid   (atom_valid),
		.o_result       (result),
		.o_result_valid (result_valid)
	);

	writeback_serializer #(.BURST_LEN(BURST_LEN)) u_wb (
		.clk            (clk),
		.rst            (rst),
		.i_result       (result),
		.i_result_valid (result_valid),
		.o_wr_en        (o_wr_en),
		.o_wr_data      (o_wr_data)
	);

endmodule

// ==== pool_engine_properties.sv ====
`timescale 1ns/1ps

module pool_engine_properties #(
	parameter int BURST_LEN = 4
) (
	input logic clk,
	input logic rst,
	input logic o_rd_en,
	input logic o_wr_en,
	input logic o_line_finish,
	input logic o_layer_finish,
	input logic o_ready
);
	int fail_cnt = 0; // Failed property count, summed into the final result
	int wr_run;       // Cycles o_wr_en has been high in the current burst

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			wr_run <= 0;
		else if (o_wr_en)
			wr_run <= wr_run + 1;
		else
			wr_run <= 0; // Idle between bursts
	end

	// A longer burst would mean a result landed on a busy serializer
	burst_len_a: assert property (@(posedge clk) disable iff (rst)
		$fell(o_wr_en) |-> (wr_run == BURST_LEN))
		else begin
			$error("o_wr_en burst lasted %0d cycles instead of %0d", wr_run, BURST_LEN);
			fail_cnt++;
		end

	layer_line_a: assert property (@(posedge clk) disable iff (rst)
		o_layer_finish |-> o_line_finish) // Layer end only on a line end
		else begin
			$error("o_layer_finish pulsed without o_line_finish");
			fail_cnt++;
		end

	ready_idle_a: assert property (@(posedge clk) disable iff (rst)
		o_ready |-> !o_rd_en)
		else begin
			$error("o_rd_en high while o_ready is high");
			fail_cnt++;
		end

endmodule

// Attached to every instance of the top level
bind pool_engine_top pool_engine_properties #(.BURST_LEN(BURST_LEN)) u_props (
	.clk            (clk),
	.rst            (rst),
	.o_rd_en        (o_rd_en),
	.o_wr_en        (o_wr_en),
	.o_line_finish  (o_line_finish),
	.o_layer_finish (o_layer_finish),
	.o_ready        (o_ready)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD = 50 // 100 ns clock
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset held over 4 rising edges, released away from the active edge
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== pool_engine_tb.sv ====
`timescale 1ns/1ps

module pool_engine_tb;
	import pool_ctrl_pkg::*;

	localparam int BURST_LEN = 4;

	logic        clk;
	logic        rst;
	logic        i_start;
	logic [2:0]  i_op;
	logic [1:0]  i_window_log2;
	logic [7:0]  i_o_side;
	logic [7:0]  i_lines;
	logic [15:0] i_data;
	logic        i_data_we;
	logic        o_rd_en;
	logic        o_wr_en;
	logic [15:0] o_wr_data;
	logic        o_line_finish;
	logic        o_layer_finish;
	logic        o_ready;

	logic [15:0] exp_q [$];  // Expected write-back words, lane order
	int          rise_q [$]; // Cycle at which each burst must start
	logic [15:0] exp_w;
	int          exp_c;
	int          cyc = 0;    // Rising edges so far
	int          limit = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          line_pulses = 0;
	int          layer_pulses = 0;
	int          bursts = 0;
	int          burst_words = 0;
	int          err0;
	int          b0;
	logic        wr_en_prev = 1'b0;
	logic        ready_due = 1'b0; // Layer end seen, o_ready due next cycle
	logic [31:0] rng = 32'd9;

	tb_clock_gen u_clk (.clk(clk), .rst(rst));

	pool_engine_top #(.BURST_LEN(BURST_LEN)) UUT (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Rounds toward minus infinity, unlike plain integer division
	function automatic int floor_div(input int num, input int den);
		int q;
		q = num / den;
		if ((num % den != 0) && (num < 0))
			q = q - 1;
		return q;
	endfunction

	// Cycle allowance of one layer
	function automatic int budget(input int wlog, input int side, input int lines);
		int windows;
		windows = side * lines;
		return 2 * (windows * (1 << wlog) * BURST_LEN + 10 * windows);
	endfunction

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Test failures found");
			$finish;
		end
	end

	// Output monitor, outputs settled since the last rising edge
	always @(negedge clk) begin
		if (!rst) begin
			if (o_wr_en) begin
				if (!wr_en_prev) begin
					bursts++;
					burst_words = 0;
					exp_c = (rise_q.size() != 0) ? rise_q.pop_front() : -1;
					assert (cyc == exp_c) else begin
						$display("Error: time %0t o_wr_en rise cycle expected %0d actual %0d",
							$time, exp_c, cyc);
						errors++;
					end
				end
				burst_words++;
				if (exp_q.size() == 0) begin
					$display("Unexpected write-back word at time %0t", $time);
					errors++;
				end else begin
					exp_w = exp_q.pop_front();
					assert (o_wr_data == exp_w) else begin
						$display("Error: time %0t o_wr_data expected %h actual %h",
							$time, exp_w, o_wr_data);
						errors++;
					end
				end
			end else if (wr_en_prev) begin
				assert (burst_words == BURST_LEN) else begin
					$display("Burst at time %0t had %0d words", $time, burst_words);
					errors++;
				end
			end
			if (ready_due) begin
				assert (o_ready && !o_rd_en) else begin
					$display("o_ready did not rise with o_rd_en low at time %0t", $time);
					errors++;
				end
			end
			ready_due = o_layer_finish;
			if (o_line_finish)
				line_pulses++;
			if (o_layer_finish) begin
				layer_pulses++;
				assert (o_line_finish) else begin
					$display("o_layer_finish without o_line_finish at time %0t", $time);
					errors++;
				end
			end
			wr_en_prev = o_wr_en;
		end
	end

	// One word per strobe, only while the engine requests data
	task automatic send_word(input logic [15:0] w, output int at);
		while (!o_rd_en)
			@(negedge clk);
		i_data    = w;
		i_data_we = 1'b1;
		at        = cyc; // Sampled at the next rising edge
		@(negedge clk);
		i_data_we = 1'b0;
	endtask

	task automatic check_reset();
		@(negedge clk);
		while (rst)
			@(negedge clk);
		assert (!o_rd_en && !o_wr_en && !o_ready && !o_line_finish && !o_layer_finish)
		else begin
			$display("Outputs not all low after reset at time %0t", $time);
			errors++;
		end
		i_op    = 3'd1; // Not a pooling opcode
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		repeat (3) begin
			assert (!o_rd_en) else begin
				$display("Error: time %0t o_rd_en expected 0 actual 1", $time);
				errors++;
			end
			@(negedge clk);
		end
	endtask

	task automatic run_layer(input logic [2:0] op, input int wlog, input int side,
		input int lines);
		int          atoms;
		int          v;
		int          at;
		int          acc [BURST_LEN];
		logic [15:0] win [$];
		logic [15:0] w;
		atoms         = 1 << wlog;
		i_op          = op;
		i_window_log2 = 2'(wlog);
		i_o_side      = 8'(side);
		i_lines       = 8'(lines);
		i_start       = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		assert (!o_ready) else begin
			$display("o_ready still high after start at time %0t", $time);
			errors++;
		end
		for (int ln = 0; ln < lines; ln++) begin
			for (int wn = 0; wn < side; wn++) begin
				win.delete();
				for (int a = 0; a < atoms; a++) begin
					for (int l = 0; l < BURST_LEN; l++) begin
						rng = xorshift32(rng);
						w   = rng[15:0];
						v   = $signed(w);
						win.push_back(w);
						if (a == 0)
							acc[l] = v;
						else if (op == OP_MPOOL)
							acc[l] = (v > acc[l]) ? v : acc[l];
						else
							acc[l] = acc[l] + v;
					end
				end
				for (int l = 0; l < BURST_LEN; l++)
					exp_q.push_back(16'(op == OP_MPOOL ? acc[l] : floor_div(acc[l], atoms)));
				foreach (win[i])
					send_word(win[i], at);
				@(negedge clk); // Idle cycle so consecutive bursts stay apart
				rise_q.push_back(at + 4); // Burst starts 3 edges after the last word
			end
			while (!o_line_finish)
				@(negedge clk);
		end
		while (!o_ready)
			@(negedge clk);
		repeat (3) begin
			assert (!o_rd_en) else begin
				$display("Error: time %0t o_rd_en expected 0 actual 1", $time);
				errors++;
			end
			@(negedge clk);
		end
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic report(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d errors", name, errors - err_before);
		end
	endtask

	initial begin
		i_start       = 1'b0;
		i_op          = '0;
		i_window_log2 = '0;
		i_o_side      = '0;
		i_lines       = '0;
		i_data        = '0;
		i_data_we     = 1'b0;
		for (int w = 0; w < 4; w++)
			limit += 2 * budget(w, 2, 2);
		limit += budget(1, 4, 1) + budget(0, 3, 2);

		err0 = errors;
		check_reset();
		report("reset and ignored opcode", err0);

		err0 = errors;
		for (int w = 0; w < 4; w++)
			run_layer(OP_MPOOL, w, 2, 2);
		report("max pooling", err0);

		err0 = errors;
		for (int w = 0; w < 4; w++)
			run_layer(OP_APOOL, w, 2, 2);
		report("average pooling", err0);

		err0 = errors;
		b0   = bursts;
		run_layer(OP_MPOOL, 1, 4, 1);
		assert (bursts - b0 == 4) else begin
			$display("Expected 4 write-back bursts, saw %0d", bursts - b0);
			errors++;
		end
		report("write-back timing", err0);

		err0         = errors;
		line_pulses  = 0;
		layer_pulses = 0;
		run_layer(OP_APOOL, 0, 3, 2);
		assert (line_pulses == 2 && layer_pulses == 1) else begin
			$display("Saw %0d line and %0d layer pulses", line_pulses, layer_pulses);
			errors++;
		end
		report("line and layer counting", err0);

		$display("Tests run %0d, failed %0d, check errors %0d, property failures %0d",
			tests_run, tests_failed, errors, UUT.u_props.fail_cnt);
		if (tests_failed == 0 && errors == 0 && UUT.u_props.fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
pool_geom_pkg.sv
pool_ctrl_pkg.sv
pool_cfg_if.sv
burst_deserializer.sv
pool_unit.sv
writeback_serializer.sv
engine_ctrl.sv
pool_engine_top.sv
pool_engine_properties.sv
tb_clock_gen.sv
pool_engine_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = pool_engine_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
RUN_FLAGS  = +verilator+error+limit+1000
PASS_TEXT  = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
